//--- verilog/merge_macros.svh
`ifndef MERGE_MACROS_SVH
`define MERGE_MACROS_SVH

// key and word width.
`define DATA_W 32

// entries per fifo.
`define FIFO_DEPTH 16

// fifo pointer width for FIFO_DEPTH entries.
`define PTR_W 4

`endif

//--- verilog/merge_pkg.sv
package merge_pkg;

	// merge fsm states.
	typedef enum logic [2:0] {
		ST_NOMINAL  = 3'b000,
		ST_TOGGLE   = 3'b001,
		ST_DONE_A   = 3'b010,
		ST_DONE_B   = 3'b011,
		ST_FINISHED = 3'b100
	} ctrl_state_e;

	// apb word addresses.
	typedef enum logic [7:0] {
		REG_CTRL     = 8'h00,
		REG_STATUS   = 8'h04,
		REG_PUSH_A   = 8'h08,
		REG_PUSH_B   = 8'h0C,
		REG_POP_OUT0 = 8'h10,
		REG_POP_OUT1 = 8'h14
	} reg_addr_e;

endpackage

//--- verilog/sync_fifo.sv
`timescale 1ns/1ps
`include "merge_macros.svh"

module sync_fifo #(
	parameter int DEPTH = `FIFO_DEPTH
) (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_push,
	input  logic [`DATA_W-1:0] i_data,
	input  logic               i_pop,
	output logic [`DATA_W-1:0] o_head,
	output logic               o_empty,
	output logic               o_full
);

	logic [`DATA_W-1:0] mem [DEPTH];
	logic [`PTR_W-1:0]  wr_ptr;
	logic [`PTR_W-1:0]  rd_ptr;
	logic [`PTR_W:0]    count;
	logic               do_push;
	logic               do_pop;

	function automatic logic [`PTR_W-1:0] next_ptr(input logic [`PTR_W-1:0] ptr);
		if (ptr == `PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign o_empty = (count == '0);
	assign o_full  = (count == (`PTR_W+1)'(DEPTH));
	assign o_head  = mem[rd_ptr]; // first word falls through.

	assign do_push = i_push & ~o_full;
	assign do_pop  = i_pop & ~o_empty;

	always_ff @(posedge i_clk) begin
		if (do_push)
			mem[wr_ptr] <= i_data;
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle or push and pop together.
			endcase
		end
	end

	// producers are expected to check the flags themselves.
	a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset) o_full |-> !i_push)
		else $error("sync_fifo: push while full.");
	a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset) o_empty |-> !i_pop)
		else $error("sync_fifo: pop while empty.");

endmodule

//--- verilog/merge_control.sv
`timescale 1ns/1ps

module merge_control (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_go,
	input  logic                   i_a_min_zero,
	input  logic                   i_b_min_zero,
	input  logic                   i_a_lte_b,
	input  logic                   i_a_empty,
	input  logic                   i_b_empty,
	input  logic                   i_r_a_min_zero,
	input  logic                   i_r_b_min_zero,
	input  logic                   i_out_full,
	output logic                   o_select_a,
	output logic                   o_stall,
	output logic                   o_switch_output,
	output merge_pkg::ctrl_state_e o_state
);

	import merge_pkg::*;

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	logic        stall;
	logic        both_drained;
	logic        term_write;
	logic        switch_q;

	assign stall = (state_q == ST_FINISHED) | i_out_full
		| ((state_q == ST_NOMINAL) & (i_a_empty | i_b_empty))
		| ((state_q == ST_DONE_A) & i_b_empty)
		| ((state_q == ST_DONE_B) & i_a_empty);

	// both inputs empty and neither left in the middle of a run.
	assign both_drained = i_a_empty & i_b_empty & i_r_a_min_zero & i_r_b_min_zero;

	// at a run boundary one zero goes out and the next run takes the other fifo.
	assign term_write = (state_q == ST_TOGGLE) & ~stall
		& ((i_a_min_zero & (i_b_min_zero | i_b_empty)) | (i_b_min_zero & i_a_empty));

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_TOGGLE: begin
				if (i_a_empty)
					state_d = ST_DONE_A;
				else if (i_b_empty)
					state_d = ST_DONE_B;
				else if (~i_a_min_zero | ~i_b_min_zero)
					state_d = ST_NOMINAL;
			end
			ST_NOMINAL: begin
				if (i_a_min_zero)
					state_d = ST_DONE_A;
				else if (i_b_min_zero)
					state_d = ST_DONE_B;
			end
			ST_DONE_A: begin
				if (both_drained)
					state_d = ST_FINISHED;
				else if (i_b_min_zero)
					state_d = ST_TOGGLE;
			end
			ST_DONE_B: begin
				if (both_drained)
					state_d = ST_FINISHED;
				else if (i_a_min_zero)
					state_d = ST_TOGGLE;
			end
			default: state_d = state_q;
		endcase
	end

	always_comb begin
		case (state_q)
			ST_NOMINAL: o_select_a = i_a_lte_b; // a wins ties.
			ST_DONE_B:  o_select_a = 1'b1;
			ST_TOGGLE:  o_select_a = i_a_min_zero;
			default:    o_select_a = 1'b0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state_q  <= ST_FINISHED;
			switch_q <= 1'b0;
		end else if (i_go) begin
			state_q  <= ST_TOGGLE;
			switch_q <= 1'b0; // run 0 goes to out0.
		end else begin
			// finishing is allowed while the drained side stalls.
			if (~stall | (state_d == ST_FINISHED))
				state_q <= state_d;
			if (term_write)
				switch_q <= ~switch_q;
		end
	end

	assign o_stall         = stall;
	assign o_switch_output = switch_q;
	assign o_state         = state_q;

	a_finished_holds: assert property (@(posedge i_clk) disable iff (i_reset)
		(state_q == ST_FINISHED && !i_go) |=> (state_q == ST_FINISHED))
		else $error("merge_control: left FINISHED without go.");

endmodule

//--- verilog/merge_datapath.sv
`timescale 1ns/1ps
`include "merge_macros.svh"

module merge_datapath (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_go,
	input  logic [`DATA_W-1:0]     i_a_head,
	input  logic [`DATA_W-1:0]     i_b_head,
	input  logic                   i_a_empty,
	input  logic                   i_b_empty,
	input  logic                   i_out0_full,
	input  logic                   i_out1_full,
	input  merge_pkg::ctrl_state_e i_state,
	input  logic                   i_select_a,
	input  logic                   i_stall,
	input  logic                   i_switch_output,
	output logic                   o_a_pop,
	output logic                   o_b_pop,
	output logic                   o_out0_push,
	output logic                   o_out1_push,
	output logic [`DATA_W-1:0]     o_out_data,
	output logic                   o_a_min_zero,
	output logic                   o_b_min_zero,
	output logic                   o_a_lte_b,
	output logic                   o_r_a_min_zero,
	output logic                   o_r_b_min_zero,
	output logic                   o_out_full
);

	import merge_pkg::*;

	logic a_zero;
	logic b_zero;
	logic move_a;
	logic move_b;
	logic push;
	logic a_mid; // side is inside a run.
	logic b_mid;

	// terminator only counts on a valid head.
	assign a_zero = ~i_a_empty & (i_a_head == '0);
	assign b_zero = ~i_b_empty & (i_b_head == '0);

	always_comb begin
		move_a = 1'b0;
		move_b = 1'b0;
		if (!i_stall) begin
			case (i_state)
				ST_NOMINAL: begin
					if (~a_zero & ~b_zero) begin
						move_a = i_select_a;
						move_b = ~i_select_a;
					end
				end
				ST_DONE_A: move_b = ~b_zero;
				ST_DONE_B: move_a = ~a_zero;
				ST_TOGGLE: begin
					// both terminators are dropped and one zero is written.
					move_a = a_zero & (b_zero | i_b_empty);
					move_b = b_zero & (a_zero | i_a_empty);
				end
				default: ;
			endcase
		end
	end

	assign push        = move_a | move_b;
	assign o_a_pop     = move_a;
	assign o_b_pop     = move_b;
	assign o_out0_push = push & ~i_switch_output;
	assign o_out1_push = push & i_switch_output;
	assign o_out_data  = i_select_a ? i_a_head : i_b_head;
	assign o_out_full  = i_switch_output ? i_out1_full : i_out0_full;

	always_ff @(posedge i_clk) begin
		if (i_reset | i_go) begin
			a_mid <= 1'b0;
			b_mid <= 1'b0;
		end else begin
			if (move_a)
				a_mid <= (i_a_head != '0);
			if (move_b)
				b_mid <= (i_b_head != '0);
		end
	end

	assign o_a_min_zero   = a_zero;
	assign o_b_min_zero   = b_zero;
	assign o_a_lte_b      = (i_a_head <= i_b_head);
	assign o_r_a_min_zero = ~a_mid;
	assign o_r_b_min_zero = ~b_mid;

endmodule

//--- verilog/merge_apb_regs.sv
`timescale 1ns/1ps
`include "merge_macros.svh"

module merge_apb_regs (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_psel,
	input  logic                   i_penable,
	input  logic                   i_pwrite,
	input  logic [7:0]             i_paddr,
	input  logic [`DATA_W-1:0]     i_pwdata,
	output logic [`DATA_W-1:0]     o_prdata,
	output logic                   o_pready,
	output logic                   o_pslverr,
	input  merge_pkg::ctrl_state_e i_state,
	input  logic                   i_a_full,
	input  logic                   i_b_full,
	input  logic                   i_out0_empty,
	input  logic                   i_out1_empty,
	input  logic [`DATA_W-1:0]     i_out0_head,
	input  logic [`DATA_W-1:0]     i_out1_head,
	output logic                   o_push_a,
	output logic                   o_push_b,
	output logic                   o_pop_out0,
	output logic                   o_pop_out1,
	output logic [`DATA_W-1:0]     o_push_data,
	output logic                   o_go
);

	import merge_pkg::*;

	reg_addr_e addr;
	logic      access;
	logic      wr;
	logic      rd;
	logic      done;

	assign addr   = reg_addr_e'(i_paddr);
	assign access = i_psel & i_penable;
	assign wr     = access & i_pwrite;
	assign rd     = access & ~i_pwrite;
	assign done   = (i_state == ST_FINISHED);

	assign o_pready    = access; // no wait states.
	assign o_push_data = i_pwdata;

	always_comb begin
		o_prdata   = '0;
		o_pslverr  = 1'b0;
		o_push_a   = 1'b0;
		o_push_b   = 1'b0;
		o_pop_out0 = 1'b0;
		o_pop_out1 = 1'b0;
		o_go       = 1'b0;
		if (access) begin
			case (addr)
				REG_CTRL:   o_go = wr & i_pwdata[0];
				REG_STATUS: o_prdata = {{(`DATA_W-2){1'b0}}, ~done, done};
				REG_PUSH_A: begin
					o_push_a  = wr & ~i_a_full; // word dropped when full.
					o_pslverr = rd | i_a_full;
				end
				REG_PUSH_B: begin
					o_push_b  = wr & ~i_b_full;
					o_pslverr = rd | i_b_full;
				end
				REG_POP_OUT0: begin
					o_pop_out0 = rd & ~i_out0_empty;
					o_pslverr  = wr | i_out0_empty;
					if (o_pop_out0)
						o_prdata = i_out0_head;
				end
				REG_POP_OUT1: begin
					o_pop_out1 = rd & ~i_out1_empty;
					o_pslverr  = wr | i_out1_empty;
					if (o_pop_out1)
						o_prdata = i_out1_head;
				end
				default: o_pslverr = 1'b1;
			endcase
		end
	end

	// a setup phase is always followed by its access phase.
	a_apb_setup_access: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_psel && !i_penable) |=> (i_psel && i_penable))
		else $error("merge_apb_regs: setup phase without access phase.");

endmodule

//--- verilog/merge_top.sv
`timescale 1ns/1ps
`include "merge_macros.svh"

module merge_top (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_psel,
	input  logic               i_penable,
	input  logic               i_pwrite,
	input  logic [7:0]         i_paddr,
	input  logic [`DATA_W-1:0] i_pwdata,
	output logic [`DATA_W-1:0] o_prdata,
	output logic               o_pready,
	output logic               o_pslverr
);

	import merge_pkg::*;

	ctrl_state_e        state;
	logic [`DATA_W-1:0] push_data;
	logic [`DATA_W-1:0] a_head;
	logic [`DATA_W-1:0] b_head;
	logic [`DATA_W-1:0] out0_head;
	logic [`DATA_W-1:0] out1_head;
	logic [`DATA_W-1:0] out_data;
	logic               push_a;
	logic               push_b;
	logic               pop_out0;
	logic               pop_out1;
	logic               go;
	logic               a_pop;
	logic               b_pop;
	logic               out0_push;
	logic               out1_push;
	logic               a_empty;
	logic               b_empty;
	logic               a_full;
	logic               b_full;
	logic               out0_empty;
	logic               out1_empty;
	logic               out0_full;
	logic               out1_full;
	logic               a_min_zero;
	logic               b_min_zero;
	logic               a_lte_b;
	logic               r_a_min_zero;
	logic               r_b_min_zero;
	logic               out_full;
	logic               select_a;
	logic               stall;
	logic               switch_output;

	merge_apb_regs u_apb (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
		.i_paddr(i_paddr), .i_pwdata(i_pwdata),
		.o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
		.i_state(state), .i_a_full(a_full), .i_b_full(b_full),
		.i_out0_empty(out0_empty), .i_out1_empty(out1_empty),
		.i_out0_head(out0_head), .i_out1_head(out1_head),
		.o_push_a(push_a), .o_push_b(push_b),
		.o_pop_out0(pop_out0), .o_pop_out1(pop_out1),
		.o_push_data(push_data), .o_go(go)
	);

	// inputs are filled by the host, outputs by the merge.
	sync_fifo fifo_a (
		.i_clk(i_clk), .i_reset(i_reset), .i_push(push_a), .i_data(push_data),
		.i_pop(a_pop), .o_head(a_head), .o_empty(a_empty), .o_full(a_full)
	);

	sync_fifo fifo_b (
		.i_clk(i_clk), .i_reset(i_reset), .i_push(push_b), .i_data(push_data),
		.i_pop(b_pop), .o_head(b_head), .o_empty(b_empty), .o_full(b_full)
	);

	sync_fifo fifo_out0 (
		.i_clk(i_clk), .i_reset(i_reset), .i_push(out0_push), .i_data(out_data),
		.i_pop(pop_out0), .o_head(out0_head), .o_empty(out0_empty), .o_full(out0_full)
	);

	sync_fifo fifo_out1 (
		.i_clk(i_clk), .i_reset(i_reset), .i_push(out1_push), .i_data(out_data),
		.i_pop(pop_out1), .o_head(out1_head), .o_empty(out1_empty), .o_full(out1_full)
	);

	merge_datapath u_datapath (
		.i_clk(i_clk), .i_reset(i_reset), .i_go(go),
		.i_a_head(a_head), .i_b_head(b_head),
		.i_a_empty(a_empty), .i_b_empty(b_empty),
		.i_out0_full(out0_full), .i_out1_full(out1_full),
		.i_state(state), .i_select_a(select_a), .i_stall(stall),
		.i_switch_output(switch_output),
		.o_a_pop(a_pop), .o_b_pop(b_pop),
		.o_out0_push(out0_push), .o_out1_push(out1_push), .o_out_data(out_data),
		.o_a_min_zero(a_min_zero), .o_b_min_zero(b_min_zero), .o_a_lte_b(a_lte_b),
		.o_r_a_min_zero(r_a_min_zero), .o_r_b_min_zero(r_b_min_zero),
		.o_out_full(out_full)
	);

	merge_control u_control (
		.i_clk(i_clk), .i_reset(i_reset), .i_go(go),
		.i_a_min_zero(a_min_zero), .i_b_min_zero(b_min_zero), .i_a_lte_b(a_lte_b),
		.i_a_empty(a_empty), .i_b_empty(b_empty),
		.i_r_a_min_zero(r_a_min_zero), .i_r_b_min_zero(r_b_min_zero),
		.i_out_full(out_full),
		.o_select_a(select_a), .o_stall(stall),
		.o_switch_output(switch_output), .o_state(state)
	);

endmodule

//--- sim/merge_checker.sv
`timescale 1ns/1ps
`include "merge_macros.svh"

module merge_checker (
	input logic               i_clk,
	input logic               i_reset,
	input logic               i_psel,
	input logic               i_penable,
	input logic               i_pwrite,
	input logic [7:0]         i_paddr,
	input logic [`DATA_W-1:0] i_prdata,
	input logic               i_pready,
	input logic               i_pslverr
);

	import merge_pkg::*;

	logic [`DATA_W-1:0] exp_out0 [$];
	logic [`DATA_W-1:0] exp_out1 [$];
	logic               wr_err_expected = 1'b0;
	int                 status_expected = -1; // status is not compared while negative.
	int                 error_count = 0;
	int                 test_errors = 0;
	int                 tests_passed = 0;
	int                 tests_failed = 0;

	task automatic add_expected(input int fifo_idx, input logic [`DATA_W-1:0] word);
		if (fifo_idx == 0)
			exp_out0.push_back(word);
		else
			exp_out1.push_back(word);
	endtask

	task automatic expect_write_error(input logic err);
		wr_err_expected = err;
	endtask

	task automatic expect_status(input int value);
		status_expected = value;
	endtask

	task automatic compare(input string name, input logic [`DATA_W-1:0] got,
		input logic [`DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic check_pop(input int fifo_idx);
		logic               have;
		logic [`DATA_W-1:0] word;
		have = (fifo_idx == 0) ? (exp_out0.size() != 0) : (exp_out1.size() != 0);
		if (!have) begin
			// empty fifo answers with an error and zero.
			compare($sformatf("out%0d pslverr", fifo_idx), i_pslverr, 1);
			compare($sformatf("out%0d prdata", fifo_idx), i_prdata, '0);
		end else begin
			if (fifo_idx == 0)
				word = exp_out0.pop_front();
			else
				word = exp_out1.pop_front();
			compare($sformatf("out%0d pslverr", fifo_idx), i_pslverr, 0);
			compare($sformatf("out%0d prdata", fifo_idx), i_prdata, word);
		end
	endtask

	always @(posedge i_clk) begin
		if (!i_reset && !(i_psel && i_penable))
			compare("pready", i_pready, 0); // idle and setup phases.
		if (!i_reset && i_psel && i_penable && i_pready) begin
			if (i_pwrite) begin
				if (i_paddr == REG_PUSH_A || i_paddr == REG_PUSH_B)
					compare("push pslverr", i_pslverr, wr_err_expected);
				else
					compare("ctrl pslverr", i_pslverr, 0);
			end else begin
				case (i_paddr)
					REG_POP_OUT0: check_pop(0);
					REG_POP_OUT1: check_pop(1);
					default: begin
						compare("status pslverr", i_pslverr, 0);
						if (status_expected >= 0)
							compare("status prdata", i_prdata, status_expected);
					end
				endcase
			end
		end
	end

	task automatic report_test(input string name);
		if (exp_out0.size() + exp_out1.size() != 0) begin
			$display("error: %s left %0d expected words unread", name,
				exp_out0.size() + exp_out1.size());
			error_count++;
			test_errors++;
			exp_out0.delete();
			exp_out1.delete();
		end
		if (test_errors == 0) begin
			$display("test %s: pass", name);
			tests_passed++;
		end else begin
			$display("test %s: fail with %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

endmodule

//--- sim/tb_merge_top.sv
`timescale 1ns/1ps
`include "merge_macros.svh"

module tb_merge_top;

	import merge_pkg::*;

	typedef logic [`DATA_W-1:0] word_q_t [$];

	localparam int DONE_POLLS  = 100;
	localparam int READY_WAITS = 16;

	logic               clk;
	logic               reset;
	logic               psel;
	logic               penable;
	logic               pwrite;
	logic [7:0]         paddr;
	logic [`DATA_W-1:0] pwdata;
	logic [`DATA_W-1:0] prdata;
	logic               pready;
	logic               pslverr;
	integer             seed = 988;

	merge_top DUT (
		.i_clk(clk), .i_reset(reset),
		.i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
		.i_paddr(paddr), .i_pwdata(pwdata),
		.o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr)
	);

	merge_checker u_checker (
		.i_clk(clk), .i_reset(reset),
		.i_psel(psel), .i_penable(penable), .i_pwrite(pwrite), .i_paddr(paddr),
		.i_prdata(prdata), .i_pready(pready), .i_pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// run k of a with run k of b, ties to a, outputs alternate per run.
	function automatic void merge_runs(input word_q_t a, input word_q_t b,
		output word_q_t out0, output word_q_t out1);
		int                 ia;
		int                 ib;
		int                 run;
		logic               a_end;
		logic               b_end;
		logic [`DATA_W-1:0] w;
		out0 = {};
		out1 = {};
		ia = 0;
		ib = 0;
		run = 0;
		while (ia < a.size() || ib < b.size()) begin
			a_end = (ia >= a.size()) || (a[ia] == '0); // missing run counts as empty.
			b_end = (ib >= b.size()) || (b[ib] == '0);
			if (a_end && b_end) begin
				w = '0;
				if (ia < a.size())
					ia++;
				if (ib < b.size())
					ib++;
			end else if (!a_end && (b_end || a[ia] <= b[ib])) begin
				w = a[ia];
				ia++;
			end else begin
				w = b[ib];
				ib++;
			end
			if (run % 2 == 0)
				out0.push_back(w);
			else
				out1.push_back(w);
			if (w == '0)
				run++;
		end
	endfunction

	task automatic apb_access(input logic write, input logic [7:0] addr,
		input logic [`DATA_W-1:0] wdata, output logic [`DATA_W-1:0] rdata);
		int waits;
		waits = 0;
		rdata = '0;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		while (!pready && waits < READY_WAITS) begin
			@(posedge clk);
			waits++;
		end
		if (!pready) begin
			$display("timeout: no pready on apb access to address %0h", addr);
			$display("SIMULATION FAILED");
			$finish;
		end else begin
			rdata = prdata;
			@(negedge clk);
			psel    = 1'b0;
			penable = 1'b0;
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [`DATA_W-1:0] data);
		logic [`DATA_W-1:0] unused;
		apb_access(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [`DATA_W-1:0] data);
		apb_access(1'b0, addr, '0, data);
	endtask

	task automatic wait_done(input string name);
		int                 polls;
		logic [`DATA_W-1:0] st;
		polls = 0;
		st = '0;
		while (st[0] == 1'b0 && polls < DONE_POLLS) begin
			apb_read(REG_STATUS, st);
			polls++;
		end
		if (st[0] == 1'b0) begin
			$display("timeout: %s never reported done", name);
			$display("SIMULATION FAILED");
			$finish;
		end
	endtask

	task automatic load_and_expect(input word_q_t a, input word_q_t b,
		output int n0, output int n1);
		word_q_t exp0;
		word_q_t exp1;
		merge_runs(a, b, exp0, exp1);
		foreach (a[i])
			apb_write(REG_PUSH_A, a[i]);
		foreach (b[i])
			apb_write(REG_PUSH_B, b[i]);
		foreach (exp0[i])
			u_checker.add_expected(0, exp0[i]);
		foreach (exp1[i])
			u_checker.add_expected(1, exp1[i]);
		n0 = exp0.size();
		n1 = exp1.size();
	endtask

	task automatic drain_outputs(input int n0, input int n1);
		logic [`DATA_W-1:0] rd;
		repeat (n0)
			apb_read(REG_POP_OUT0, rd);
		repeat (n1)
			apb_read(REG_POP_OUT1, rd);
	endtask

	task automatic merge_case(input string name, input word_q_t a, input word_q_t b);
		int                 n0;
		int                 n1;
		logic [`DATA_W-1:0] rd;
		load_and_expect(a, b, n0, n1);
		apb_write(REG_CTRL, 1);
		wait_done(name);
		drain_outputs(n0, n1);
		apb_read(REG_POP_OUT0, rd); // no words beyond the expected ones.
		apb_read(REG_POP_OUT1, rd);
	endtask

	// up to three runs of up to three nondecreasing keys.
	task automatic gen_runs(output word_q_t q);
		int                 nruns;
		int                 len;
		logic [`DATA_W-1:0] key;
		logic [31:0]        r;
		q = {};
		r = $random(seed);
		nruns = 1 + int'(r[7:0]) % 3;
		for (int run = 0; run < nruns; run++) begin
			r = $random(seed);
			len = int'(r[1:0]);
			key = 1 + r[5:2];
			for (int i = 0; i < len; i++) begin
				q.push_back(key);
				r = $random(seed);
				key = key + r[2:0];
			end
			q.push_back('0);
		end
	endtask

	initial begin
		word_q_t            a;
		word_q_t            b;
		int                 n0;
		int                 n1;
		logic [`DATA_W-1:0] rd;
		reset   = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (8)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		u_checker.expect_status(1); // done and idle until the first go.
		apb_read(REG_STATUS, rd);
		u_checker.expect_status(-1);
		u_checker.report_test("reset_status");

		a = '{3, 5, 5, 9, 0};
		b = '{1, 5, 7, 12, 0};
		merge_case("single_pair", a, b);
		u_checker.report_test("single_pair");

		a = '{2, 4, 0, 1, 0, 6, 8, 10, 0};
		b = '{3, 0, 1, 2, 3, 0, 7, 0};
		merge_case("three_pairs", a, b);
		u_checker.report_test("three_pairs");

		a = '{0, 5, 6, 0, 9, 0}; // a opens with an empty run and has one run more than b.
		b = '{4, 8, 0, 0};
		merge_case("uneven_runs", a, b);
		u_checker.report_test("uneven_runs");

		a = {};
		b = {};
		for (int i = 0; i < `FIFO_DEPTH / 2 + 2; i++) begin
			a.push_back(2 * i + 2);
			b.push_back(2 * i + 1);
		end
		a.push_back('0);
		b.push_back('0);
		load_and_expect(a, b, n0, n1);
		apb_write(REG_CTRL, 1);
		u_checker.expect_status(2); // busy while out0 is full.
		repeat (20)
			apb_read(REG_STATUS, rd);
		u_checker.expect_status(-1);
		drain_outputs(n0, n1);
		wait_done("backpressure");
		apb_read(REG_POP_OUT0, rd);
		u_checker.report_test("backpressure");

		apb_read(REG_POP_OUT0, rd);
		apb_read(REG_POP_OUT1, rd);
		a = {};
		b = {};
		for (int i = 1; i < `FIFO_DEPTH; i++)
			a.push_back(3 * i);
		a.push_back('0);
		load_and_expect(a, b, n0, n1);
		u_checker.expect_write_error(1'b1);
		apb_write(REG_PUSH_A, 32'h5A5A); // fifo a is full so the word is dropped.
		u_checker.expect_write_error(1'b0);
		apb_write(REG_CTRL, 1);
		wait_done("apb_errors");
		drain_outputs(n0, n1);
		apb_read(REG_POP_OUT0, rd);
		u_checker.report_test("apb_errors");

		for (int round = 0; round < 6; round++) begin
			gen_runs(a);
			gen_runs(b);
			merge_case("random", a, b);
		end
		u_checker.report_test("random");

		$display("tests passed %0d, failed %0d, errors %0d", u_checker.tests_passed,
			u_checker.tests_failed, u_checker.error_count);
		if (u_checker.error_count == 0 && u_checker.tests_failed == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- files.f
+incdir+verilog
verilog/merge_pkg.sv
verilog/sync_fifo.sv
verilog/merge_control.sv
verilog/merge_datapath.sv
verilog/merge_apb_regs.sv
verilog/merge_top.sv
sim/merge_checker.sv
sim/tb_merge_top.sv

//--- Bender.yml
package:
  name: merge_stage

export_include_dirs:
  - verilog

sources:
  - verilog/merge_pkg.sv
  - verilog/sync_fifo.sv
  - verilog/merge_control.sv
  - verilog/merge_datapath.sv
  - verilog/merge_apb_regs.sv
  - verilog/merge_top.sv
  - target: simulation
    files:
      - sim/merge_checker.sv
      - sim/tb_merge_top.sv
